// File: Bender.yml
# TX configuration and monitor block of the serial link
package:
  name: etx_cfg

sources:
  # Packages first, modules in dependency order
  - logic/emesh_pkg.sv
  - logic/etx_regmap_pkg.sv
  - logic/etx_status_sync.sv
  - logic/etx_cfg.sv
  - logic/etx_top.sv

  # Self-checking testbench, top module etx_cfg_tb
  - target: test
    files:
      - tests/etx_cfg_tb.sv

# RTL top level is etx_top
# Stimulus file tests/etx_cfg_tests.txt is read from the project root

// File: all.f
logic/emesh_pkg.sv
logic/etx_regmap_pkg.sv
logic/etx_status_sync.sv
logic/etx_cfg.sv
logic/etx_top.sv
tests/etx_cfg_tb.sv

// File: logic/emesh_pkg.sv
package emesh_pkg;

   //##########################################################################
   // Widths
   //##########################################################################
   localparam int AW = 32;                // Address and data word
   localparam int PW = 2*AW + 40;         // Flat packet, 104 bits

   typedef logic [AW-1:0] addr_t;         // Address or data word
   typedef logic [PW-1:0] packet_t;       // Whole mesh packet

   typedef logic [3:0] ctrlmode_t;        // Ctrlmode tag as driven to the serializer
   typedef logic [4:0] ctrlmode_field_t;  // Full ctrlmode field in the packet
   typedef logic [1:0] datamode_t;        // Transfer size code

   //##########################################################################
   // Field positions in the flat packet
   //##########################################################################
   localparam int WRITE_BIT = 0;          // 1 = write, 0 = read

   localparam int DATAMODE_LSB = 1;
   localparam int DATAMODE_MSB = 2;

   // Five bits, top bit dropped on forward
   localparam int CTRLMODE_LSB = 3;
   localparam int CTRLMODE_MSB = 7;

   localparam int DSTADDR_LSB = 8;        // Target address
   localparam int DSTADDR_MSB = DSTADDR_LSB + AW - 1;

   localparam int DATA_LSB = DSTADDR_MSB + 1;
   localparam int DATA_MSB = DATA_LSB + AW - 1;

   // Return address for read responses
   localparam int SRCADDR_LSB = DATA_MSB + 1;
   localparam int SRCADDR_MSB = SRCADDR_LSB + AW - 1;

endpackage

// File: logic/etx_cfg.sv
`timescale 1ns/1ps

module etx_cfg
(
   input  logic                      clk,
   input  logic                      nreset,
   input  logic                      cfg_access,      // Register access strobe
   input  logic                      etx_access,      // Transmit traffic strobe
   input  logic                      etx_wait,        // Freezes the forward stage
   input  emesh_pkg::packet_t        etx_packet,
   input  etx_regmap_pkg::status_t   status_sync,     // Already synchronized
   output logic                      cfg_mmu_access,
   output logic                      etx_cfg_access,  // Toward the receive side
   output emesh_pkg::packet_t        etx_cfg_packet,
   output logic                      tx_enable,
   output logic                      mmu_enable,
   output logic                      gpio_enable,     // Pins forced to gpio_data
   output logic                      remap_enable,
   output logic                      burst_enable,
   output etx_regmap_pkg::gpio_t     gpio_data,
   output emesh_pkg::ctrlmode_t      ctrlmode,
   output logic                      ctrlmode_bypass
);

   //##########################################################################
   // Packet fields
   //##########################################################################
   logic                         write_in;
   emesh_pkg::datamode_t         datamode_in;
   emesh_pkg::ctrlmode_field_t   ctrlmode_in;
   emesh_pkg::addr_t             dstaddr_in;
   emesh_pkg::addr_t             data_in;
   emesh_pkg::addr_t             srcaddr_in;

   assign write_in    = etx_packet[emesh_pkg::WRITE_BIT];
   assign datamode_in = etx_packet[emesh_pkg::DATAMODE_MSB:emesh_pkg::DATAMODE_LSB];
   assign ctrlmode_in = etx_packet[emesh_pkg::CTRLMODE_MSB:emesh_pkg::CTRLMODE_LSB];
   assign dstaddr_in  = etx_packet[emesh_pkg::DSTADDR_MSB:emesh_pkg::DSTADDR_LSB];
   assign data_in     = etx_packet[emesh_pkg::DATA_MSB:emesh_pkg::DATA_LSB];
   assign srcaddr_in  = etx_packet[emesh_pkg::SRCADDR_MSB:emesh_pkg::SRCADDR_LSB];

   //##########################################################################
   // Decode
   //##########################################################################
   etx_regmap_pkg::reg_idx_t reg_idx;
   logic tx_match;
   logic ecfg_read;
   logic ecfg_write;
   logic version_we;
   logic cfg_we;
   logic status_we;
   logic gpio_we;
   logic monitor_we;

   assign reg_idx = dstaddr_in[etx_regmap_pkg::REG_IDX_MSB:etx_regmap_pkg::REG_IDX_LSB];

   // MMR space and TX sub group
   assign tx_match =
      cfg_access &
      (dstaddr_in[etx_regmap_pkg::GROUP_MSB:etx_regmap_pkg::GROUP_LSB] ==
       etx_regmap_pkg::GROUP_MMR) &
      (dstaddr_in[etx_regmap_pkg::TXGRP_MSB:etx_regmap_pkg::TXGRP_LSB] ==
       etx_regmap_pkg::GROUP_TX);

   // Lower half of the MMU group only
   assign cfg_mmu_access =
      cfg_access &
      (dstaddr_in[etx_regmap_pkg::GROUP_MSB:etx_regmap_pkg::GROUP_LSB] ==
       etx_regmap_pkg::GROUP_MMU) &
      ~dstaddr_in[etx_regmap_pkg::MMU_SEL_BIT];

   assign ecfg_read  = tx_match & ~write_in;
   assign ecfg_write = tx_match &  write_in;

   assign version_we = ecfg_write & (reg_idx == etx_regmap_pkg::REG_VERSION);
   assign cfg_we     = ecfg_write & (reg_idx == etx_regmap_pkg::REG_CFG);
   assign status_we  = ecfg_write & (reg_idx == etx_regmap_pkg::REG_STATUS);
   assign gpio_we    = ecfg_write & (reg_idx == etx_regmap_pkg::REG_GPIO);
   assign monitor_we = ecfg_write & (reg_idx == etx_regmap_pkg::REG_MONITOR);

   //##########################################################################
   // Register file
   //##########################################################################
   etx_regmap_pkg::cfg_t      tx_cfg_reg;
   etx_regmap_pkg::gpio_t     tx_gpio_reg;
   etx_regmap_pkg::version_t  tx_version_reg;
   etx_regmap_pkg::status_t   tx_status_reg;
   emesh_pkg::addr_t          tx_monitor_reg;
   emesh_pkg::addr_t          tx_packet_reg;   // Last transmitted dstaddr
   logic                      mon_inc;

   assign mon_inc = etx_access & ~etx_wait;     // One transaction accepted

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         tx_cfg_reg     <= '0;
         tx_gpio_reg    <= '0;
         tx_version_reg <= etx_regmap_pkg::VERSION_RESET;
         tx_status_reg  <= '0;
         tx_monitor_reg <= '0;
         tx_packet_reg  <= '0;
      end
      else
      begin
         if (cfg_we)
            tx_cfg_reg <= data_in[15:0];
         if (gpio_we)
            tx_gpio_reg <= data_in[8:0];
         if (version_we)
            tx_version_reg <= data_in[15:0];
         // Write replaces, otherwise accumulate new events
         if (status_we)
            tx_status_reg <= data_in[15:0];
         else
            tx_status_reg <= tx_status_reg | status_sync;
         if (monitor_we)
            tx_monitor_reg <= data_in;
         else
            tx_monitor_reg <= tx_monitor_reg + {{(emesh_pkg::AW-1){1'b0}}, mon_inc};
         if (etx_access)
            tx_packet_reg <= dstaddr_in;          // Debug sampler
      end
   end

   // Static controls
   assign tx_enable       = tx_cfg_reg[etx_regmap_pkg::CFG_TX_EN];
   assign mmu_enable      = tx_cfg_reg[etx_regmap_pkg::CFG_MMU_EN];
   assign remap_enable    =
      (tx_cfg_reg[etx_regmap_pkg::CFG_REMAP_MSB:etx_regmap_pkg::CFG_REMAP_LSB] ==
       etx_regmap_pkg::REMAP_ON);
   assign ctrlmode        =
      tx_cfg_reg[etx_regmap_pkg::CFG_CTRLMODE_MSB:etx_regmap_pkg::CFG_CTRLMODE_LSB];
   assign ctrlmode_bypass = tx_cfg_reg[etx_regmap_pkg::CFG_BYPASS];
   assign burst_enable    = tx_cfg_reg[etx_regmap_pkg::CFG_BURST];
   assign gpio_enable     =
      (tx_cfg_reg[etx_regmap_pkg::CFG_GPIO_MSB:etx_regmap_pkg::CFG_GPIO_LSB] ==
       etx_regmap_pkg::GPIO_ON);
   assign gpio_data       = tx_gpio_reg;

   //##########################################################################
   // Readback
   //##########################################################################
   emesh_pkg::addr_t rd_mux;
   emesh_pkg::addr_t cfg_dout;

   always_comb
   begin
      case (reg_idx)
         etx_regmap_pkg::REG_VERSION: rd_mux = {16'h0000, tx_version_reg};
         etx_regmap_pkg::REG_CFG:     rd_mux = {16'h0000, tx_cfg_reg};
         etx_regmap_pkg::REG_STATUS:  rd_mux = {16'h0000, tx_status_reg};
         etx_regmap_pkg::REG_GPIO:    rd_mux = {23'h000000, tx_gpio_reg};
         etx_regmap_pkg::REG_MONITOR: rd_mux = tx_monitor_reg;
         etx_regmap_pkg::REG_PACKET:  rd_mux = tx_packet_reg;
         default:                     rd_mux = '0;   // Unmapped index reads zero
      endcase
   end

   // Same timing as the forward stage, so data lines up with its packet
   always_ff @(posedge clk)
   begin
      if (!nreset)
         cfg_dout <= '0;
      else if (!etx_wait)
         cfg_dout <= ecfg_read ? rd_mux : '0;
   end

   //##########################################################################
   // Forward stage
   //##########################################################################
   logic                         write_out;
   logic                         read_sel;
   emesh_pkg::datamode_t         datamode_out;
   emesh_pkg::ctrlmode_field_t   ctrlmode_out;
   emesh_pkg::addr_t             dstaddr_out;
   emesh_pkg::addr_t             data_out;
   emesh_pkg::addr_t             srcaddr_out;
   emesh_pkg::addr_t             data_mux;

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         etx_cfg_access <= 1'b0;
         read_sel       <= 1'b0;
         write_out      <= 1'b0;
         datamode_out   <= '0;
         ctrlmode_out   <= '0;
         dstaddr_out    <= '0;
         data_out       <= '0;
         srcaddr_out    <= '0;
      end
      else if (!etx_wait)                       // Hold everything on wait
      begin
         etx_cfg_access <= cfg_access;
         read_sel       <= ecfg_read;
         write_out      <= write_in | ecfg_read;   // Read turns into write
         datamode_out   <= datamode_in;
         ctrlmode_out   <= {1'b0, ctrlmode_in[3:0]};
         dstaddr_out    <= ecfg_read ? srcaddr_in : dstaddr_in;  // Back to requester
         data_out       <= data_in;
         srcaddr_out    <= srcaddr_in;
      end
   end

   assign data_mux = read_sel ? cfg_dout : data_out;

   // Pack outgoing packet
   always_comb
   begin
      etx_cfg_packet[emesh_pkg::WRITE_BIT] = write_out;
      etx_cfg_packet[emesh_pkg::DATAMODE_MSB:emesh_pkg::DATAMODE_LSB] = datamode_out;
      etx_cfg_packet[emesh_pkg::CTRLMODE_MSB:emesh_pkg::CTRLMODE_LSB] = ctrlmode_out;
      etx_cfg_packet[emesh_pkg::DSTADDR_MSB:emesh_pkg::DSTADDR_LSB]   = dstaddr_out;
      etx_cfg_packet[emesh_pkg::DATA_MSB:emesh_pkg::DATA_LSB]         = data_mux;
      etx_cfg_packet[emesh_pkg::SRCADDR_MSB:emesh_pkg::SRCADDR_LSB]   = srcaddr_out;
   end

endmodule

// File: logic/etx_regmap_pkg.sv
package etx_regmap_pkg;

   //##########################################################################
   // Address decode
   //##########################################################################
   localparam int RFAW = 6;                            // Register index width
   localparam int REG_IDX_LSB = 2;                     // Word aligned
   localparam int REG_IDX_MSB = REG_IDX_LSB + RFAW - 1;

   localparam int GROUP_LSB = 16;                      // Group code in dstaddr
   localparam int GROUP_MSB = 19;
   localparam logic [3:0] GROUP_MMR = 4'hf;            // Memory mapped registers
   localparam logic [3:0] GROUP_MMU = 4'he;            // MMU table
   localparam int MMU_SEL_BIT = 15;                    // Must be low for MMU

   // Sub group inside MMR space
   localparam int TXGRP_LSB = 8;
   localparam int TXGRP_MSB = 10;
   localparam logic [2:0] GROUP_TX = 3'b000;

   typedef logic [RFAW-1:0] reg_idx_t;
   typedef logic [15:0]     status_t;                  // Sticky status bits
   typedef logic [8:0]      gpio_t;                    // Static pin values
   typedef logic [15:0]     cfg_t;                     // Config register
   typedef logic [15:0]     version_t;

   // Register indices
   localparam reg_idx_t REG_VERSION = 6'd0;
   localparam reg_idx_t REG_CFG     = 6'd1;
   localparam reg_idx_t REG_STATUS  = 6'd2;
   localparam reg_idx_t REG_GPIO    = 6'd3;
   localparam reg_idx_t REG_MONITOR = 6'd4;
   localparam reg_idx_t REG_PACKET  = 6'd5;            // Read only sampler

   localparam version_t VERSION_RESET = 16'h0102;

   //##########################################################################
   // Config register fields
   //##########################################################################
   localparam int CFG_TX_EN        = 0;
   localparam int CFG_MMU_EN       = 1;
   localparam int CFG_REMAP_LSB    = 2;
   localparam int CFG_REMAP_MSB    = 3;
   localparam int CFG_CTRLMODE_LSB = 4;
   localparam int CFG_CTRLMODE_MSB = 7;
   localparam int CFG_BYPASS       = 9;
   localparam int CFG_BURST        = 10;
   localparam int CFG_GPIO_LSB     = 10;                // Overlaps burst bit
   localparam int CFG_GPIO_MSB     = 11;
   localparam logic [1:0] REMAP_ON = 2'b01;
   localparam logic [1:0] GPIO_ON  = 2'b01;

endpackage

// File: logic/etx_status_sync.sv
`timescale 1ns/1ps

module etx_status_sync
(
   input  logic                    clk,
   input  logic                    nreset,
   input  etx_regmap_pkg::status_t din,   // Asynchronous status lines
   output etx_regmap_pkg::status_t dout   // Safe in clk domain
);

   // First stage, may go metastable
   etx_regmap_pkg::status_t sync_q1;

   // Two flops back to back
   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         sync_q1 <= '0;
         dout    <= '0;
      end
      else
      begin
         sync_q1 <= din;
         dout    <= sync_q1;      // Settled by now
      end
   end

endmodule

// File: logic/etx_top.sv
`timescale 1ns/1ps

module etx_top
(
   input  logic                      clk,
   input  logic                      nreset,
   // Access side
   input  logic                      cfg_access,
   input  logic                      etx_access,
   input  emesh_pkg::packet_t        etx_packet,
   input  logic                      etx_wait,
   input  etx_regmap_pkg::status_t   tx_status,        // From another clock domain
   // Forward path toward RX
   output logic                      etx_cfg_access,
   output emesh_pkg::packet_t        etx_cfg_packet,
   output logic                      cfg_mmu_access,
   // Static transmitter controls
   output logic                      tx_enable,
   output logic                      mmu_enable,
   output logic                      gpio_enable,
   output logic                      remap_enable,
   output logic                      burst_enable,
   output etx_regmap_pkg::gpio_t     gpio_data,
   output emesh_pkg::ctrlmode_t      ctrlmode,
   output logic                      ctrlmode_bypass
);

   //##########################################################################
   // Status crossing
   //##########################################################################
   etx_regmap_pkg::status_t status_sync;   // tx_status in clk domain

   etx_status_sync u_sync
   (
      .clk    (clk),
      .nreset (nreset),
      .din    (tx_status),
      .dout   (status_sync)
   );

   //##########################################################################
   // Register block
   //##########################################################################
   etx_cfg u_cfg
   (
      .clk             (clk),
      .nreset          (nreset),
      .cfg_access      (cfg_access),
      .etx_access      (etx_access),
      .etx_wait        (etx_wait),
      .etx_packet      (etx_packet),
      .status_sync     (status_sync),
      .cfg_mmu_access  (cfg_mmu_access),
      .etx_cfg_access  (etx_cfg_access),
      .etx_cfg_packet  (etx_cfg_packet),
      .tx_enable       (tx_enable),
      .mmu_enable      (mmu_enable),
      .gpio_enable     (gpio_enable),
      .remap_enable    (remap_enable),
      .burst_enable    (burst_enable),
      .gpio_data       (gpio_data),
      .ctrlmode        (ctrlmode),
      .ctrlmode_bypass (ctrlmode_bypass)
   );

endmodule

// File: tests/etx_cfg_tb.sv
`timescale 1ns/1ps

module etx_cfg_tb;

   //#########################################################################
   // Constants and signals
   //#########################################################################
   localparam int COLS         = 7;      // Words per operation line
   localparam int MAX_OPS      = 64;
   localparam int RESET_CYCLES = 10;
   localparam int OP_CYCLES    = 40;     // Timeout budget per operation
   localparam logic [31:0] OP_WRITE   = 32'd1;
   localparam logic [31:0] OP_READ    = 32'd2;
   localparam logic [31:0] OP_TRAFFIC = 32'd3;

   logic                    clk = 1'b0;
   logic                    nreset;
   logic                    cfg_access;
   logic                    etx_access;
   emesh_pkg::packet_t      etx_packet;
   logic                    etx_wait;
   etx_regmap_pkg::status_t tx_status;
   logic                    etx_cfg_access;
   emesh_pkg::packet_t      etx_cfg_packet;
   logic                    cfg_mmu_access;
   logic                    tx_enable;
   logic                    mmu_enable;
   logic                    gpio_enable;
   logic                    remap_enable;
   logic                    burst_enable;
   etx_regmap_pkg::gpio_t   gpio_data;
   emesh_pkg::ctrlmode_t    ctrlmode;
   logic                    ctrlmode_bypass;

   logic [31:0] ops [0:COLS*MAX_OPS-1];     // Flat copy of the operations file
   int          num_ops;
   int          cycle_limit = 0;
   int          cycle_count = 0;
   int          mismatch_errors = 0;
   int          other_errors = 0;
   int          seed = 32'h588a;
   logic [15:0] cfg_model;                  // Expected config register
   logic [8:0]  gpio_model;

   always #2 clk = ~clk;                    // 4 ns period

   etx_top u_dut
   (
      .clk             (clk),
      .nreset          (nreset),
      .cfg_access      (cfg_access),
      .etx_access      (etx_access),
      .etx_packet      (etx_packet),
      .etx_wait        (etx_wait),
      .tx_status       (tx_status),
      .etx_cfg_access  (etx_cfg_access),
      .etx_cfg_packet  (etx_cfg_packet),
      .cfg_mmu_access  (cfg_mmu_access),
      .tx_enable       (tx_enable),
      .mmu_enable      (mmu_enable),
      .gpio_enable     (gpio_enable),
      .remap_enable    (remap_enable),
      .burst_enable    (burst_enable),
      .gpio_data       (gpio_data),
      .ctrlmode        (ctrlmode),
      .ctrlmode_bypass (ctrlmode_bypass)
   );

   //#########################################################################
   // Helpers
   //#########################################################################
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input int op_no);
      begin
         assert (got === exp)
         else
         begin
            $display("Mismatch %s: expected %h, got %h (op %0d)", name, exp, got, op_no);
            mismatch_errors++;
         end
      end
   endtask

   function automatic emesh_pkg::packet_t build_packet(input logic wr,
      input emesh_pkg::datamode_t dm, input emesh_pkg::ctrlmode_field_t cm,
      input emesh_pkg::addr_t dst, input emesh_pkg::addr_t dat, input emesh_pkg::addr_t src);
      emesh_pkg::packet_t p;
      begin
         p = '0;
         p[emesh_pkg::WRITE_BIT] = wr;
         p[emesh_pkg::DATAMODE_MSB:emesh_pkg::DATAMODE_LSB] = dm;
         p[emesh_pkg::CTRLMODE_MSB:emesh_pkg::CTRLMODE_LSB] = cm;
         p[emesh_pkg::DSTADDR_MSB:emesh_pkg::DSTADDR_LSB]   = dst;
         p[emesh_pkg::DATA_MSB:emesh_pkg::DATA_LSB]         = dat;
         p[emesh_pkg::SRCADDR_MSB:emesh_pkg::SRCADDR_LSB]   = src;
         build_packet = p;
      end
   endfunction

   // MMR group and TX sub group
   function automatic logic tx_group(input logic [31:0] dst);
      tx_group = (dst[19:16] == 4'hf) && (dst[10:8] == 3'b000);
   endfunction

   // Lower half of the MMU group only
   function automatic logic mmu_rule(input logic [31:0] dst);
      mmu_rule = (dst[19:16] == 4'he) && !dst[15];
   endfunction

   task automatic check_controls(input int n);
      begin
         check_value("tx_enable", tx_enable, cfg_model[0], n);
         check_value("mmu_enable", mmu_enable, cfg_model[1], n);
         check_value("remap_enable", remap_enable, cfg_model[3:2] == 2'b01, n);
         check_value("ctrlmode", ctrlmode, cfg_model[7:4], n);
         check_value("ctrlmode_bypass", ctrlmode_bypass, cfg_model[9], n);
         check_value("burst_enable", burst_enable, cfg_model[10], n);
         check_value("gpio_enable", gpio_enable, cfg_model[11:10] == 2'b01, n);
         check_value("gpio_data", gpio_data, gpio_model, n);
      end
   endtask

   // Config and GPIO writes of the TX group
   task automatic update_reg_model(input logic [31:0] op, input logic [31:0] dst,
                                   input logic [31:0] dat);
      begin
         if (op == OP_WRITE && tx_group(dst) && dst[7:2] == etx_regmap_pkg::REG_CFG)
            cfg_model = dat[15:0];
         if (op == OP_WRITE && tx_group(dst) && dst[7:2] == etx_regmap_pkg::REG_GPIO)
            gpio_model = dat[8:0];
      end
   endtask

   //#########################################################################
   // One operation from the file
   //#########################################################################
   task automatic run_op(input int n);
      logic [31:0]                op;
      logic [31:0]                dst;
      logic [31:0]                src;
      logic [31:0]                dat;
      logic [31:0]                exp;
      logic [15:0]                st;
      int                         waits;
      emesh_pkg::ctrlmode_field_t cm;
      emesh_pkg::datamode_t       dm;
      logic                       resp;    // TX read answered with data
      begin
         op    = ops[n*COLS];
         dst   = ops[n*COLS+1];
         src   = ops[n*COLS+2];
         dat   = ops[n*COLS+3];
         waits = ops[n*COLS+4] + ({$random(seed)} % 3);   // File count plus 0 to 2
         st    = ops[n*COLS+5];
         exp   = ops[n*COLS+6];
         cm    = $random(seed);
         dm    = $random(seed);
         resp  = (op == OP_READ) && tx_group(dst);
         if (op != OP_WRITE && op != OP_READ && op != OP_TRAFFIC)
         begin
            $display("Operation %0d has an unknown opcode %h", n, op);
            other_errors++;
         end
         // Status pattern gets three edges to reach the sticky register
         @(posedge clk);
         tx_status <= st;
         repeat (3) @(posedge clk);
         cfg_access <= (op == OP_WRITE) || (op == OP_READ);
         etx_access <= (op == OP_TRAFFIC);
         etx_packet <= build_packet(op == OP_WRITE, dm, cm, dst, dat, src);
         etx_wait   <= (waits != 0);
         @(negedge clk);
         check_value("cfg_mmu_access", cfg_mmu_access, (op != OP_TRAFFIC) && mmu_rule(dst), n);
         check_value("etx_cfg_access", etx_cfg_access, 1'b0, n);   // Nothing forwarded yet
         for (int k = 0; k < waits; k++)
         begin
            @(posedge clk);
            etx_wait <= (k + 1 < waits);
            update_reg_model(op, dst, dat);   // Writes land even under wait
            @(negedge clk);
            check_value("etx_cfg_access", etx_cfg_access, 1'b0, n);   // Stage frozen
            check_controls(n);
         end
         @(posedge clk);                   // Access taken on this edge
         cfg_access <= 1'b0;
         etx_access <= 1'b0;
         etx_packet <= '0;
         update_reg_model(op, dst, dat);
         @(negedge clk);
         check_value("etx_cfg_access", etx_cfg_access, op != OP_TRAFFIC, n);
         if (op == OP_WRITE || op == OP_READ)
         begin
            check_value("etx_cfg_packet.write", etx_cfg_packet[emesh_pkg::WRITE_BIT],
                        (op == OP_WRITE) || resp, n);
            check_value("etx_cfg_packet.datamode",
                        etx_cfg_packet[emesh_pkg::DATAMODE_MSB:emesh_pkg::DATAMODE_LSB], dm, n);
            check_value("etx_cfg_packet.ctrlmode",
                        etx_cfg_packet[emesh_pkg::CTRLMODE_MSB:emesh_pkg::CTRLMODE_LSB],
                        {1'b0, cm[3:0]}, n);   // Bit 4 dropped
            check_value("etx_cfg_packet.dstaddr",
                        etx_cfg_packet[emesh_pkg::DSTADDR_MSB:emesh_pkg::DSTADDR_LSB],
                        resp ? src : dst, n);
            check_value("etx_cfg_packet.data",
                        etx_cfg_packet[emesh_pkg::DATA_MSB:emesh_pkg::DATA_LSB],
                        resp ? exp : dat, n);
            check_value("etx_cfg_packet.srcaddr",
                        etx_cfg_packet[emesh_pkg::SRCADDR_MSB:emesh_pkg::SRCADDR_LSB], src, n);
         end
         check_controls(n);
      end
   endtask

   //#########################################################################
   // Main sequence
   //#########################################################################
   initial
   begin
      nreset     <= 1'b0;
      cfg_access <= 1'b0;
      etx_access <= 1'b0;
      etx_packet <= '0;
      etx_wait   <= 1'b0;
      tx_status  <= '0;
      cfg_model  = '0;
      gpio_model = '0;
      for (int i = 0; i < COLS*MAX_OPS; i++)
         ops[i] = '0;
      $readmemh("tests/etx_cfg_tests.txt", ops);
      num_ops = 0;
      while (num_ops < MAX_OPS && ops[num_ops*COLS] != 0)
         num_ops++;
      if (num_ops == 0)
      begin
         $display("No operations were loaded from the operations file");
         other_errors++;
      end
      cycle_limit = RESET_CYCLES + OP_CYCLES * (num_ops + 1);
      repeat (RESET_CYCLES) @(posedge clk);
      nreset <= 1'b1;
      for (int n = 0; n < num_ops; n++)
         run_op(n);
      repeat (2) @(posedge clk);
      $display("Checks finished with %0d mismatches and %0d other errors",
               mismatch_errors, other_errors);
      if (mismatch_errors == 0 && other_errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   // Watchdog
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit)
      begin
         $display("Timeout after %0d cycles, the operations did not complete", cycle_count);
         $display("Simulation failed");
         $finish;
      end
   end

endmodule

// File: tests/etx_cfg_tests.txt
// op dstaddr srcaddr data waits tx_status expected (all hex)
// op 1 register write, 2 register read, 3 transmit traffic, 0 ends the list
// Reset values
2 000f0000 80000010 00000000 0 0000 00000102
2 000f0004 80000020 00000000 1 0000 00000000
2 000f0008 80000030 00000000 0 0000 00000000
2 000f000c 80000040 00000000 0 0000 00000000
2 000f0010 80000050 00000000 0 0000 00000000
2 000f0014 80000060 00000000 2 0000 00000000
2 000f003c 80000068 00000000 0 0000 00000000
// Config and GPIO
1 000f0004 80000070 ffff06b7 0 0000 00000000
2 000f0004 80000080 00000000 0 0000 000006b7
1 000f000c 80000090 000003a5 1 0000 00000000
2 000f000c 800000a0 00000000 0 0000 000001a5
1 000f0004 800000b0 00000c0a 0 0000 00000000
2 000f0004 800000c0 12345678 1 0000 00000c0a
1 000f0004 800000d0 00000b1d 0 0000 00000000
1 000f0004 800000e0 00000405 2 0000 00000000
1 000f0104 800000f0 0000ffff 0 0000 00000000
2 000f0004 800000f8 00000000 0 0000 00000405
// Non TX accesses and MMU flag
1 000e0100 80000100 cafef00d 0 0000 00000000
2 000e0200 80000110 00000000 1 0000 00000000
1 000e8004 80000120 0badbeef 0 0000 00000000
2 000f0300 80000130 13572468 0 0000 00000000
1 7fe00000 80000140 a5a5a5a5 2 0000 00000000
// Monitor and sampler
1 000f0010 80000200 00000100 0 0000 00000000
3 10000000 00000000 00000000 1 0000 00000000
3 10000040 00000000 00000000 0 0000 00000000
3 20000080 00000000 00000000 2 0000 00000000
3 300000c4 00000000 00000000 0 0000 00000000
2 000f0010 80000210 00000000 0 0000 00000104
2 000f0014 80000220 00000000 1 0000 300000c4
3 400000f0 00000000 00000000 3 0000 00000000
3 50000008 00000000 00000000 0 0000 00000000
2 000f0010 80000230 00000000 0 0000 00000106
2 000f0014 80000240 00000000 0 0000 50000008
// Sticky status
1 000f0008 80000300 00000000 0 0000 00000000
2 000f0008 80000310 00000000 0 0011 00000011
2 000f0008 80000320 00000000 1 0300 00000311
2 000f0008 80000330 00000000 0 0000 00000311
1 000f0008 80000340 00004000 0 0000 00000000
2 000f0008 80000350 00000000 0 0002 00004002
1 000f0008 80000360 00000000 1 0000 00000000
2 000f0008 80000370 00000000 0 0000 00000000
2 000f0000 80000380 00000000 0 0000 00000102
0 00000000 00000000 00000000 0 0000 00000000
